//--- axi_rob_macros.svh
`ifndef AXI_ROB_MACROS_SVH
`define AXI_ROB_MACROS_SVH

// ==================================================
// Field widths shared by the source and sink sides
// ==================================================

// The ID must be wide enough to carry a read slot index
`define AXI_ROB_ID_W 4
`define AXI_ROB_USER_W 4
`define AXI_ROB_ADDR_W 16
`define AXI_ROB_DATA_W 32

// Burst length is encoded as beats minus one
`define AXI_ROB_LEN_W 2

// ==================================================
// Buffer depths
// ==================================================

// Slot counts are powers of two so the ring pointers wrap by themselves
`define AXI_ROB_WR_ENTRIES 8
`define AXI_ROB_RD_ENTRIES 16
`define AXI_ROB_FIFO_DEPTH 4

`endif

//--- axi_rob_pkg.sv
`default_nettype none

`include "axi_rob_macros.svh"

package axi_rob_pkg;

    // Basic field types, shared by every channel struct
    typedef logic [`AXI_ROB_ID_W-1:0] axi_id_t;
    typedef logic [`AXI_ROB_USER_W-1:0] axi_user_t;
    typedef logic [`AXI_ROB_ADDR_W-1:0] axi_addr_t;
    typedef logic [`AXI_ROB_DATA_W-1:0] axi_data_t;
    typedef logic [`AXI_ROB_LEN_W-1:0] axi_len_t;
    typedef logic [1:0] axi_resp_t;

    // Response codes, as on a normal AXI bus
    localparam axi_resp_t resp_okay = 2'b00;
    localparam axi_resp_t resp_slverr = 2'b10;

    // Write request, always a single beat
    typedef struct packed {
        axi_id_t id;
        axi_user_t user;
        axi_addr_t addr;
    } axi_aw_t;

    // Write data beat
    typedef struct packed {
        axi_data_t data;
        logic last;
    } axi_w_t;

    // Write response
    typedef struct packed {
        axi_id_t id;
        axi_user_t user;
        axi_resp_t resp;
    } axi_b_t;

    // Read request, len + 1 beats
    typedef struct packed {
        axi_id_t id;
        axi_user_t user;
        axi_addr_t addr;
        axi_len_t len;
    } axi_ar_t;

    // Read data beat
    typedef struct packed {
        axi_id_t id;
        axi_user_t user;
        axi_data_t data;
        axi_resp_t resp;
        logic last;
    } axi_r_t;

    // The source tag saved in a reorder slot and put back on the response
    typedef struct packed {
        axi_id_t id;
        axi_user_t user;
    } axi_meta_t;

endpackage

`default_nettype wire

//--- flow_fifo.sv
`timescale 1ns/1ps
`default_nettype none

// Small valid/ready FIFO. The output is taken straight from the storage
// registers, so nothing passes combinationally from input to output
module flow_fifo
#(
    parameter int DEPTH = 4,
    parameter type data_t = logic
)
(
    input  logic  mem_source,
    input  logic  reset,

    input  logic  in_valid,
    input  data_t in_data,
    output logic  in_ready,
    output logic  almost_full,

    output logic  out_valid,
    output data_t out_data,
    input  logic  out_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] cnt_t;

    data_t mem [DEPTH];
    ptr_t wr_ptr;
    ptr_t rd_ptr;
    cnt_t count;
    logic push;
    logic pop;

    // Step a pointer around the ring, whatever the depth is
    function automatic ptr_t next_ptr(input ptr_t ptr);
        return (ptr == ptr_t'(DEPTH - 1)) ? '0 : ptr + ptr_t'(1);
    endfunction

    assign push = in_valid && in_ready;
    assign pop = out_valid && out_ready;

    assign in_ready = (count != cnt_t'(DEPTH));

    // Raised with two or fewer slots left. That leaves room for a push
    // already in flight when the producer sees the flag
    assign almost_full = ((cnt_t'(DEPTH) - count) <= cnt_t'(2));

    assign out_valid = (count != '0);
    assign out_data = mem[rd_ptr];

    always_ff @(posedge mem_source)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop)
            begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // Count moves only when exactly one side is active
            if (push && !pop)
            begin
                count <= count + cnt_t'(1);
            end
            else if (pop && !push)
            begin
                count <= count - cnt_t'(1);
            end
        end
    end

    always_ff @(posedge mem_source)
    begin
        if (push)
        begin
            mem[wr_ptr] <= in_data;
        end
    end

endmodule

`default_nettype wire

//--- rob_buffer.sv
`timescale 1ns/1ps
`default_nettype none

// Reorder buffer. Slots are handed out in request order, filled by the sink
// in whatever order it answers, and drained again in request order
module rob_buffer
#(
    parameter int N_ENTRIES = 8,
    parameter int MAX_ALLOC = 1,
    parameter type data_t = logic
)
(
    input  logic                           mem_source,
    input  logic                           reset,

    // Allocation side
    input  logic                           alloc_en,
    input  logic [$clog2(MAX_ALLOC):0]     alloc_cnt,
    input  axi_rob_pkg::axi_meta_t         alloc_meta,
    output logic                           not_full,
    output logic [$clog2(N_ENTRIES)-1:0]   alloc_idx,

    // Fill side, written by the sink responses
    input  logic                           enq_en,
    input  logic [$clog2(N_ENTRIES)-1:0]   enq_idx,
    input  data_t                          enq_data,

    // Drain side
    input  logic                           deq_en,
    output logic                           not_empty,
    output data_t                          first_data,
    output axi_rob_pkg::axi_meta_t         first_meta
);

    localparam int IDX_W = $clog2(N_ENTRIES);
    localparam int CNT_W = IDX_W + 1;

    typedef logic [IDX_W-1:0] idx_t;
    typedef logic [CNT_W-1:0] cnt_t;

    // Ring pointers. N_ENTRIES is a power of two, so they wrap on overflow
    idx_t alloc_ptr;
    idx_t head_ptr;

    // Number of slots not yet allocated
    cnt_t free_cnt;
    cnt_t alloc_amt;
    cnt_t free_amt;

    // One bit per slot, set when the sink has written the slot
    logic [N_ENTRIES-1:0] filled;

    // Slot storage
    data_t data_mem [N_ENTRIES];
    axi_rob_pkg::axi_meta_t meta_mem [N_ENTRIES];

    // ==================================================
    // Status outputs
    // ==================================================

    assign alloc_idx = alloc_ptr;

    // Space for the largest possible allocation is needed, whatever is asked
    assign not_full = (free_cnt >= cnt_t'(MAX_ALLOC));

    // The head may only leave once its own data has arrived
    assign not_empty = filled[head_ptr];

    assign alloc_amt = alloc_en ? cnt_t'(alloc_cnt) : '0;
    assign free_amt = deq_en ? cnt_t'(1) : '0;

    // ==================================================
    // Pointers, free count and filled bits
    // ==================================================

    always_ff @(posedge mem_source)
    begin
        if (reset)
        begin
            alloc_ptr <= '0;
            head_ptr <= '0;
            free_cnt <= cnt_t'(N_ENTRIES);
            filled <= '0;
        end
        else
        begin
            // A multi-beat request claims consecutive slots
            if (alloc_en)
            begin
                alloc_ptr <= alloc_ptr + idx_t'(alloc_cnt);
            end

            if (deq_en)
            begin
                head_ptr <= head_ptr + idx_t'(1);
            end

            free_cnt <= free_cnt - alloc_amt + free_amt;

            // The sink never writes the slot being drained, so the two
            // updates below always touch different bits
            if (enq_en)
            begin
                filled[enq_idx] <= 1'b1;
            end
            if (deq_en)
            begin
                filled[head_ptr] <= 1'b0;
            end
        end
    end

    // ==================================================
    // Storage and registered drain outputs
    // ==================================================

    always_ff @(posedge mem_source)
    begin
        // Meta goes only to the first slot of an allocation
        // Later beats of a burst take their tag from the first one
        if (alloc_en)
        begin
            meta_mem[alloc_ptr] <= alloc_meta;
        end

        if (enq_en)
        begin
            data_mem[enq_idx] <= enq_data;
        end

        // Head entry shows up on the outputs one cycle after the strobe
        if (deq_en)
        begin
            first_data <= data_mem[head_ptr];
            first_meta <= meta_mem[head_ptr];
        end
    end

endmodule

`default_nettype wire

//--- axi_mem_rob.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_rob_macros.svh"

// Memory shim that puts out-of-order sink responses back into request order.
// The sink sees reorder slot indices as IDs; the source sees its own IDs
module axi_mem_rob
(
    input  logic                   mem_source,
    input  logic                   reset,

    // Source side
    input  axi_rob_pkg::axi_aw_t   src_aw,
    input  logic                   src_awvalid,
    output logic                   src_awready,
    input  axi_rob_pkg::axi_w_t    src_w,
    input  logic                   src_wvalid,
    output logic                   src_wready,
    output axi_rob_pkg::axi_b_t    src_b,
    output logic                   src_bvalid,
    input  logic                   src_bready,
    input  axi_rob_pkg::axi_ar_t   src_ar,
    input  logic                   src_arvalid,
    output logic                   src_arready,
    output axi_rob_pkg::axi_r_t    src_r,
    output logic                   src_rvalid,
    input  logic                   src_rready,

    // Sink side. Responses have no ready since every slot is reserved
    output axi_rob_pkg::axi_aw_t   snk_aw,
    output logic                   snk_awvalid,
    input  logic                   snk_awready,
    output axi_rob_pkg::axi_w_t    snk_w,
    output logic                   snk_wvalid,
    input  logic                   snk_wready,
    input  axi_rob_pkg::axi_b_t    snk_b,
    input  logic                   snk_bvalid,
    output axi_rob_pkg::axi_ar_t   snk_ar,
    output logic                   snk_arvalid,
    input  logic                   snk_arready,
    input  axi_rob_pkg::axi_r_t    snk_r,
    input  logic                   snk_rvalid
);

    localparam int WR_IDX_W = $clog2(`AXI_ROB_WR_ENTRIES);
    localparam int RD_IDX_W = $clog2(`AXI_ROB_RD_ENTRIES);
    localparam int RD_MAX_ALLOC = 1 << `AXI_ROB_LEN_W;

    typedef logic [WR_IDX_W-1:0] wr_idx_t;
    typedef logic [RD_IDX_W-1:0] rd_idx_t;
    typedef logic [`AXI_ROB_LEN_W:0] rd_cnt_t;

    // ==================================================
    // Write path
    // ==================================================

    logic wr_not_full;
    logic aw_fifo_ready;
    logic wr_not_empty;
    logic wr_deq;
    logic wr_deq_q;
    logic b_almost_full;
    wr_idx_t wr_alloc_idx;
    axi_rob_pkg::axi_resp_t wr_first_data;
    axi_rob_pkg::axi_meta_t wr_first_meta;
    axi_rob_pkg::axi_aw_t aw_slot;
    axi_rob_pkg::axi_b_t b_rsp;

    // A request needs a reorder slot and room in the AW FIFO
    assign src_awready = wr_not_full && aw_fifo_ready;

    // Sink sees the slot index in place of the source ID
    always_comb
    begin
        aw_slot = src_aw;
        aw_slot.id = axi_rob_pkg::axi_id_t'(wr_alloc_idx);
    end

    rob_buffer #(
        .N_ENTRIES(`AXI_ROB_WR_ENTRIES),
        .MAX_ALLOC(1),
        .data_t(axi_rob_pkg::axi_resp_t)
    ) wr_rob (
        .mem_source(mem_source),
        .reset(reset),
        .alloc_en(src_awvalid && src_awready),
        .alloc_cnt(1'b1),
        .alloc_meta('{id: src_aw.id, user: src_aw.user}),
        .not_full(wr_not_full),
        .alloc_idx(wr_alloc_idx),
        .enq_en(snk_bvalid),
        .enq_idx(wr_idx_t'(snk_b.id)),
        .enq_data(snk_b.resp),
        .deq_en(wr_deq),
        .not_empty(wr_not_empty),
        .first_data(wr_first_data),
        .first_meta(wr_first_meta)
    );

    flow_fifo #(.DEPTH(`AXI_ROB_FIFO_DEPTH), .data_t(axi_rob_pkg::axi_aw_t)) aw_fifo (
        .mem_source(mem_source),
        .reset(reset),
        .in_valid(src_awvalid && src_awready),
        .in_data(aw_slot),
        .in_ready(aw_fifo_ready),
        .almost_full(),
        .out_valid(snk_awvalid),
        .out_data(snk_aw),
        .out_ready(snk_awready)
    );

    // Write data does not depend on AW at all
    flow_fifo #(.DEPTH(`AXI_ROB_FIFO_DEPTH), .data_t(axi_rob_pkg::axi_w_t)) w_fifo (
        .mem_source(mem_source),
        .reset(reset),
        .in_valid(src_wvalid),
        .in_data(src_w),
        .in_ready(src_wready),
        .almost_full(),
        .out_valid(snk_wvalid),
        .out_data(snk_w),
        .out_ready(snk_wready)
    );

    // Drain whenever the head is ready and the B FIFO has room.
    // The strobe is delayed one cycle to line up with the buffer outputs
    assign wr_deq = wr_not_empty && !b_almost_full;
    assign b_rsp = '{id: wr_first_meta.id, user: wr_first_meta.user, resp: wr_first_data};

    always_ff @(posedge mem_source)
    begin
        if (reset)
        begin
            wr_deq_q <= 1'b0;
        end
        else
        begin
            wr_deq_q <= wr_deq;
        end
    end

    flow_fifo #(.DEPTH(`AXI_ROB_FIFO_DEPTH), .data_t(axi_rob_pkg::axi_b_t)) b_fifo (
        .mem_source(mem_source),
        .reset(reset),
        .in_valid(wr_deq_q),
        .in_data(b_rsp),
        .in_ready(),
        .almost_full(b_almost_full),
        .out_valid(src_bvalid),
        .out_data(src_b),
        .out_ready(src_bready)
    );

    // ==================================================
    // Read path
    // ==================================================

    logic rd_not_full;
    logic ar_fifo_ready;
    logic rd_not_empty;
    logic rd_deq;
    logic rd_deq_q;
    logic r_almost_full;
    logic rd_sop;
    rd_idx_t rd_alloc_idx;
    rd_idx_t rd_enq_idx;
    rd_cnt_t rd_alloc_cnt;
    logic [`AXI_ROB_LEN_W-1:0] rd_beat_off;
    axi_rob_pkg::axi_r_t rd_first_data;
    axi_rob_pkg::axi_meta_t rd_first_meta;
    axi_rob_pkg::axi_meta_t rd_hold_meta;
    axi_rob_pkg::axi_ar_t ar_slot;
    axi_rob_pkg::axi_r_t r_rsp;

    // The buffer only reports not_full with room for a maximum burst,
    // which covers the len + 1 slots this request takes
    assign src_arready = rd_not_full && ar_fifo_ready;
    assign rd_alloc_cnt = rd_cnt_t'(src_ar.len) + rd_cnt_t'(1);

    always_comb
    begin
        ar_slot = src_ar;
        ar_slot.id = axi_rob_pkg::axi_id_t'(rd_alloc_idx);
    end

    // Beats of a burst arrive in order, so a running offset from the
    // first slot finds each beat's slot
    assign rd_enq_idx = rd_idx_t'(snk_r.id) + rd_idx_t'(rd_beat_off);

    always_ff @(posedge mem_source)
    begin
        if (reset)
        begin
            rd_beat_off <= '0;
        end
        else if (snk_rvalid)
        begin
            rd_beat_off <= snk_r.last ? '0 : rd_beat_off + 1'b1;
        end
    end

    rob_buffer #(
        .N_ENTRIES(`AXI_ROB_RD_ENTRIES),
        .MAX_ALLOC(RD_MAX_ALLOC),
        .data_t(axi_rob_pkg::axi_r_t)
    ) rd_rob (
        .mem_source(mem_source),
        .reset(reset),
        .alloc_en(src_arvalid && src_arready),
        .alloc_cnt(rd_alloc_cnt),
        .alloc_meta('{id: src_ar.id, user: src_ar.user}),
        .not_full(rd_not_full),
        .alloc_idx(rd_alloc_idx),
        .enq_en(snk_rvalid),
        .enq_idx(rd_enq_idx),
        .enq_data(snk_r),
        .deq_en(rd_deq),
        .not_empty(rd_not_empty),
        .first_data(rd_first_data),
        .first_meta(rd_first_meta)
    );

    flow_fifo #(.DEPTH(`AXI_ROB_FIFO_DEPTH), .data_t(axi_rob_pkg::axi_ar_t)) ar_fifo (
        .mem_source(mem_source),
        .reset(reset),
        .in_valid(src_arvalid && src_arready),
        .in_data(ar_slot),
        .in_ready(ar_fifo_ready),
        .almost_full(),
        .out_valid(snk_arvalid),
        .out_data(snk_ar),
        .out_ready(snk_arready)
    );

    assign rd_deq = rd_not_empty && !r_almost_full;

    // Only the first slot of a burst holds valid meta. Capture it there
    // and reuse it for the remaining beats
    always_ff @(posedge mem_source)
    begin
        if (reset)
        begin
            rd_deq_q <= 1'b0;
            rd_sop <= 1'b1;
        end
        else
        begin
            rd_deq_q <= rd_deq;
            if (rd_deq_q)
            begin
                rd_sop <= rd_first_data.last;
            end
        end
    end

    always_ff @(posedge mem_source)
    begin
        if (rd_deq_q && rd_sop)
        begin
            rd_hold_meta <= rd_first_meta;
        end
    end

    always_comb
    begin
        r_rsp = rd_first_data;
        if (rd_sop)
        begin
            r_rsp.id = rd_first_meta.id;
            r_rsp.user = rd_first_meta.user;
        end
        else
        begin
            r_rsp.id = rd_hold_meta.id;
            r_rsp.user = rd_hold_meta.user;
        end
    end

    flow_fifo #(.DEPTH(`AXI_ROB_FIFO_DEPTH), .data_t(axi_rob_pkg::axi_r_t)) r_fifo (
        .mem_source(mem_source),
        .reset(reset),
        .in_valid(rd_deq_q),
        .in_data(r_rsp),
        .in_ready(),
        .almost_full(r_almost_full),
        .out_valid(src_rvalid),
        .out_data(src_r),
        .out_ready(src_rready)
    );

endmodule

`default_nettype wire

//--- tb_mem_sink.sv
`timescale 1ns/1ps
`default_nettype none

// Memory sink for the testbench. It takes requests with random ready gaps
// and answers a randomly chosen pending one, so responses come back out of order
module tb_mem_sink
(
    input  logic                  mem_source,
    input  logic                  reset,
    input  axi_rob_pkg::axi_aw_t  snk_aw,
    input  logic                  snk_awvalid,
    output logic                  snk_awready,
    output logic                  snk_wready,
    output axi_rob_pkg::axi_b_t   snk_b,
    output logic                  snk_bvalid,
    input  axi_rob_pkg::axi_ar_t  snk_ar,
    input  logic                  snk_arvalid,
    output logic                  snk_arready,
    output axi_rob_pkg::axi_r_t   snk_r,
    output logic                  snk_rvalid
);

    integer seed;

    // Requests seen on the bus and not yet answered
    axi_rob_pkg::axi_aw_t wr_q [$];
    axi_rob_pkg::axi_ar_t rd_q [$];

    // Read burst being sent, one beat per cycle
    axi_rob_pkg::axi_ar_t cur_ar;
    logic in_burst;
    int beat;

    // Upper half of the address space answers with an error
    function automatic axi_rob_pkg::axi_resp_t resp_for_addr(input axi_rob_pkg::axi_addr_t addr);
        return addr[15] ? axi_rob_pkg::resp_slverr : axi_rob_pkg::resp_okay;
    endfunction

    initial
    begin
        seed = 32'h3ae3;
        in_burst = 1'b0;
        beat = 0;
        snk_awready = 1'b0;
        snk_wready = 1'b0;
        snk_arready = 1'b0;
        snk_b = '0;
        snk_bvalid = 1'b0;
        snk_r = '0;
        snk_rvalid = 1'b0;
    end

    // Handshakes are sampled mid cycle, where both sides are settled
    always @(negedge mem_source)
    begin
        if (reset)
        begin
            wr_q.delete();
            rd_q.delete();
        end
        else
        begin
            if (snk_awvalid && snk_awready)
            begin
                wr_q.push_back(snk_aw);
            end
            if (snk_arvalid && snk_arready)
            begin
                rd_q.push_back(snk_ar);
            end
        end
    end

    always @(posedge mem_source)
    begin
        int pick;
        #1;
        snk_awready = ($random(seed) & 3) != 0;
        snk_wready = ($random(seed) & 3) != 0;
        snk_arready = ($random(seed) & 3) != 0;
        // There is no ready on B or R, so a raised valid always transfers
        snk_bvalid = 1'b0;
        snk_rvalid = 1'b0;
        if (reset)
        begin
            in_burst = 1'b0;
        end
        else
        begin
            if (wr_q.size() > 0 && ($random(seed) & 1) != 0)
            begin
                pick = ($random(seed) & 32'h7fffffff) % wr_q.size();
                snk_b.id = wr_q[pick].id;
                snk_b.user = '0;
                snk_b.resp = resp_for_addr(wr_q[pick].addr);
                snk_bvalid = 1'b1;
                wr_q.delete(pick);
            end
            // A burst is sent whole before the next one may start
            if (!in_burst && rd_q.size() > 0 && ($random(seed) & 1) != 0)
            begin
                pick = ($random(seed) & 32'h7fffffff) % rd_q.size();
                cur_ar = rd_q[pick];
                rd_q.delete(pick);
                in_burst = 1'b1;
                beat = 0;
            end
            if (in_burst)
            begin
                snk_r.id = cur_ar.id;
                snk_r.user = '0;
                snk_r.data = axi_rob_pkg::axi_data_t'(cur_ar.addr) + axi_rob_pkg::axi_data_t'(beat);
                snk_r.data = snk_r.data ^ 32'h5a5a0000;
                snk_r.resp = resp_for_addr(cur_ar.addr);
                snk_r.last = (beat == int'(cur_ar.len));
                snk_rvalid = 1'b1;
                if (snk_r.last)
                begin
                    in_burst = 1'b0;
                end
                else
                begin
                    beat++;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- tb_axi_mem_rob.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_rob_macros.svh"

// Testbench for the reorder shim. A random source drives both request paths,
// and queues in issue order predict every response and every sink request
module tb_axi_mem_rob;

    localparam int N_WR = 200;
    localparam int N_RD = 200;
    // Forty cycles for each transaction
    localparam int TIMEOUT = 40 * (N_WR + N_RD);

    logic mem_source;
    logic reset;

    axi_rob_pkg::axi_aw_t src_aw;
    logic src_awvalid;
    logic src_awready;
    axi_rob_pkg::axi_w_t src_w;
    logic src_wvalid;
    logic src_wready;
    axi_rob_pkg::axi_b_t src_b;
    logic src_bvalid;
    logic src_bready;
    axi_rob_pkg::axi_ar_t src_ar;
    logic src_arvalid;
    logic src_arready;
    axi_rob_pkg::axi_r_t src_r;
    logic src_rvalid;
    logic src_rready;

    axi_rob_pkg::axi_aw_t snk_aw;
    logic snk_awvalid;
    logic snk_awready;
    axi_rob_pkg::axi_w_t snk_w;
    logic snk_wvalid;
    logic snk_wready;
    axi_rob_pkg::axi_b_t snk_b;
    logic snk_bvalid;
    axi_rob_pkg::axi_ar_t snk_ar;
    logic snk_arvalid;
    logic snk_arready;
    axi_rob_pkg::axi_r_t snk_r;
    logic snk_rvalid;

    integer seed;
    int err_cnt = 0;
    int check_cnt = 0;
    int cycle_cnt = 0;
    int aw_sent;
    int w_sent;
    int ar_sent;
    int wr_slot;
    int rd_slot;
    int b_stall;
    int r_stall;
    logic run;
    logic any_accept;
    logic aw_fire;
    logic w_fire;
    logic ar_fire;

    // Expected traffic, oldest first
    axi_rob_pkg::axi_b_t exp_b [$];
    axi_rob_pkg::axi_r_t exp_r [$];
    axi_rob_pkg::axi_aw_t exp_snk_aw [$];
    axi_rob_pkg::axi_w_t exp_snk_w [$];
    axi_rob_pkg::axi_ar_t exp_snk_ar [$];

    axi_mem_rob axi_mem_rob_inst (.*);

    tb_mem_sink sink_inst (.*);

    initial
    begin
        mem_source = 1'b0;
    end

    always #2 mem_source = ~mem_source;

    always @(posedge mem_source) cycle_cnt <= cycle_cnt + 1;

    // ==================================================
    // Helpers
    // ==================================================

    function automatic axi_rob_pkg::axi_resp_t resp_for_addr(input axi_rob_pkg::axi_addr_t addr);
        return addr[15] ? axi_rob_pkg::resp_slverr : axi_rob_pkg::resp_okay;
    endfunction

    function automatic logic all_done();
        return aw_sent == N_WR && w_sent == N_WR && ar_sent == N_RD &&
               exp_b.size() == 0 && exp_r.size() == 0 && exp_snk_aw.size() == 0 &&
               exp_snk_w.size() == 0 && exp_snk_ar.size() == 0;
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        err_cnt++;
        $display("Error: %s = %h, expected %h at cycle %0d", name, got, exp, cycle_cnt);
    endtask

    task automatic report_failure(input string what);
        err_cnt++;
        $display("Error: %s at cycle %0d", what, cycle_cnt);
    endtask

    // Mostly random ready, with now and then a long stall that fills the shim
    task automatic step_ready(inout int stall, output logic ready);
        if (stall > 0)
        begin
            stall--;
            ready = 1'b0;
        end
        else if (($random(seed) & 127) == 0)
        begin
            stall = 40 + ($random(seed) & 63);
            ready = 1'b0;
        end
        else
        begin
            ready = ($random(seed) & 3) != 0;
        end
    endtask

    task automatic end_run();
        $display("Summary: %0d writes, %0d reads, %0d checks, %0d errors",
                 aw_sent, ar_sent, check_cnt, err_cnt);
        if (err_cnt == 0)
        begin
            $display("Simulation completed successfully");
        end
        else
        begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    // ==================================================
    // Reset, run control and timeout
    // ==================================================

    initial
    begin
        seed = 32'h3ae3;
        reset = 1'b1;
        run = 1'b0;
        any_accept = 1'b0;
        aw_fire = 1'b0;
        w_fire = 1'b0;
        ar_fire = 1'b0;
        aw_sent = 0;
        w_sent = 0;
        ar_sent = 0;
        wr_slot = 0;
        rd_slot = 0;
        b_stall = 0;
        r_stall = 0;
        src_aw = '0;
        src_awvalid = 1'b0;
        src_w = '0;
        src_wvalid = 1'b0;
        src_bready = 1'b0;
        src_ar = '0;
        src_arvalid = 1'b0;
        src_rready = 1'b0;
        repeat (16) @(posedge mem_source);
        #1;
        reset = 1'b0;
        // A few idle cycles show that no valid rises on its own
        repeat (4) @(posedge mem_source);
        run = 1'b1;
        while (!all_done())
        begin
            @(posedge mem_source);
        end
        // Quiet tail so a duplicated response would still be caught
        repeat (32) @(posedge mem_source);
        end_run();
    end

    initial
    begin
        wait (cycle_cnt >= TIMEOUT);
        err_cnt++;
        $display("Timeout: transactions still outstanding after %0d cycles", TIMEOUT);
        end_run();
    end

    // ==================================================
    // Source stimulus
    // ==================================================

    always @(posedge mem_source)
    begin
        logic [31:0] rnd;
        #1;
        if (run)
        begin
            // A new request is only offered once the previous one is taken
            if (aw_fire || !src_awvalid)
            begin
                rnd = $random(seed);
                src_awvalid = (aw_sent < N_WR) && (rnd[1:0] != 2'b00);
                src_aw.id = rnd[7:4];
                src_aw.user = rnd[11:8];
                src_aw.addr = rnd[31:16];
            end
            if (w_fire || !src_wvalid)
            begin
                rnd = $random(seed);
                src_wvalid = (w_sent < N_WR) && rnd[0];
                src_w.data = $random(seed);
                src_w.last = 1'b1;
            end
            if (ar_fire || !src_arvalid)
            begin
                rnd = $random(seed);
                src_arvalid = (ar_sent < N_RD) && (rnd[1:0] != 2'b00);
                src_ar.len = rnd[3:2];
                src_ar.id = rnd[7:4];
                src_ar.user = rnd[11:8];
                src_ar.addr = rnd[31:16];
            end
            step_ready(b_stall, src_bready);
            step_ready(r_stall, src_rready);
        end
    end

    // ==================================================
    // Model and checks, sampled mid cycle
    // ==================================================

    always @(negedge mem_source)
    begin
        axi_rob_pkg::axi_b_t b_exp;
        axi_rob_pkg::axi_r_t r_exp;
        axi_rob_pkg::axi_aw_t aw_exp;
        axi_rob_pkg::axi_ar_t ar_exp;
        axi_rob_pkg::axi_w_t w_exp;
        if (!reset)
        begin
            aw_fire = src_awvalid && src_awready;
            w_fire = src_wvalid && src_wready;
            ar_fire = src_arvalid && src_arready;

            // Nothing may be valid until the first request goes in
            if (!any_accept)
            begin
                check_cnt++;
                assert ({src_bvalid, src_rvalid, snk_awvalid, snk_wvalid, snk_arvalid} == 5'b0)
                else report_mismatch("{src_bvalid,src_rvalid,snk_awvalid,snk_wvalid,snk_arvalid}",
                    {src_bvalid, src_rvalid, snk_awvalid, snk_wvalid, snk_arvalid}, 64'h0);
            end
            if (aw_fire || w_fire || ar_fire)
            begin
                any_accept = 1'b1;
            end

            // Write slots step by one and wrap at the buffer size
            if (aw_fire)
            begin
                b_exp.id = src_aw.id;
                b_exp.user = src_aw.user;
                b_exp.resp = resp_for_addr(src_aw.addr);
                exp_b.push_back(b_exp);
                aw_exp = src_aw;
                aw_exp.id = axi_rob_pkg::axi_id_t'(wr_slot);
                exp_snk_aw.push_back(aw_exp);
                wr_slot = (wr_slot + 1) % `AXI_ROB_WR_ENTRIES;
                aw_sent++;
            end
            if (w_fire)
            begin
                exp_snk_w.push_back(src_w);
                w_sent++;
            end
            // Read slots step by the burst length
            if (ar_fire)
            begin
                ar_exp = src_ar;
                ar_exp.id = axi_rob_pkg::axi_id_t'(rd_slot);
                exp_snk_ar.push_back(ar_exp);
                rd_slot = (rd_slot + int'(src_ar.len) + 1) % `AXI_ROB_RD_ENTRIES;
                for (int b = 0; b <= int'(src_ar.len); b++)
                begin
                    r_exp.id = src_ar.id;
                    r_exp.user = src_ar.user;
                    r_exp.data = axi_rob_pkg::axi_data_t'(src_ar.addr) +
                                 axi_rob_pkg::axi_data_t'(b);
                    r_exp.data = r_exp.data ^ 32'h5a5a0000;
                    r_exp.resp = resp_for_addr(src_ar.addr);
                    r_exp.last = (b == int'(src_ar.len));
                    exp_r.push_back(r_exp);
                end
                ar_sent++;
            end

            if (snk_awvalid && snk_awready)
            begin
                check_cnt++;
                assert (exp_snk_aw.size() > 0)
                else report_failure("sink AW request with no write issued");
                if (exp_snk_aw.size() > 0)
                begin
                    aw_exp = exp_snk_aw.pop_front();
                    assert (snk_aw === aw_exp)
                    else report_mismatch("snk_aw", snk_aw, aw_exp);
                end
            end
            if (snk_wvalid && snk_wready)
            begin
                check_cnt++;
                assert (exp_snk_w.size() > 0)
                else report_failure("sink W beat with no write data issued");
                if (exp_snk_w.size() > 0)
                begin
                    w_exp = exp_snk_w.pop_front();
                    assert (snk_w === w_exp)
                    else report_mismatch("snk_w", snk_w, w_exp);
                end
            end
            if (snk_arvalid && snk_arready)
            begin
                check_cnt++;
                assert (exp_snk_ar.size() > 0)
                else report_failure("sink AR request with no read issued");
                if (exp_snk_ar.size() > 0)
                begin
                    ar_exp = exp_snk_ar.pop_front();
                    assert (snk_ar === ar_exp)
                    else report_mismatch("snk_ar", snk_ar, ar_exp);
                end
            end

            // Responses must come back in issue order with the source tag
            if (src_bvalid && src_bready)
            begin
                check_cnt++;
                assert (exp_b.size() > 0)
                else report_failure("write response returned with no write outstanding");
                if (exp_b.size() > 0)
                begin
                    b_exp = exp_b.pop_front();
                    assert (src_b === b_exp)
                    else report_mismatch("src_b", src_b, b_exp);
                end
            end
            if (src_rvalid && src_rready)
            begin
                check_cnt++;
                assert (exp_r.size() > 0)
                else report_failure("read beat returned with no read outstanding");
                if (exp_r.size() > 0)
                begin
                    r_exp = exp_r.pop_front();
                    assert (src_r === r_exp)
                    else report_mismatch("src_r", src_r, r_exp);
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+.
axi_rob_pkg.sv
flow_fifo.sv
rob_buffer.sv
axi_mem_rob.sv
tb_mem_sink.sv
tb_axi_mem_rob.sv
